// File: source/node_pkg.sv
`default_nettype none

package node_pkg;

	// ==================================================
	// Bus widths
	// ==================================================
	localparam int ADDR_W = 32;                     // APB address width
	localparam int DATA_W = 32;                     // APB data width, also the RAM word
	localparam int STRB_W = 4;                      // One strobe per byte lane
	localparam int BYTE_W = DATA_W / STRB_W;        // Bits covered by one strobe

	// ==================================================
	// Address map
	// ==================================================
	// Each region is word addressed from bit 2 up and spans its depth in words
	localparam logic [ADDR_W-1:0] RAM_BASE   = 32'h0000_0000;
	localparam int                RAM_WORDS  = 1024;
	localparam logic [ADDR_W-1:0] SPAD_BASE  = 32'h0004_0000;
	localparam int                SPAD_WORDS = 256;
	localparam logic [ADDR_W-1:0] CAUSE_BASE = 32'h0005_0000;

	// Word address widths of the two memories, main RAM being the deeper one
	localparam int RAM_AW  = $clog2(RAM_WORDS);
	localparam int SPAD_AW = $clog2(SPAD_WORDS);

	// ==================================================
	// Interrupt cause table
	// ==================================================
	localparam int IRQ_LEVELS = 8;                  // Level 0 means no request
	localparam int IRQ_W      = $clog2(IRQ_LEVELS); // Priority level width
	localparam int CAUSE_W    = 8;                  // Cause code stored per level

	// ==================================================
	// Memory timing
	// ==================================================
	// Read data shows up this many clocks after the enable cycle
	localparam int MEM_LATENCY = 2;
	// Wide enough to count down the wait states of one RAM transfer
	localparam int LAT_CNT_W   = $clog2(MEM_LATENCY + 1);

	// Target of a decoded bus address
	typedef enum logic [1:0] {
		REG_RAM   = 2'd0,  // Main RAM
		REG_SPAD  = 2'd1,  // Scratchpad RAM
		REG_CAUSE = 2'd2,  // Read-only cause table
		REG_NONE  = 2'd3   // Unmapped, answers with an error
	} region_t;

endpackage

`default_nettype wire

// File: source/mem_port_if.sv
`timescale 1ns/1ns
`default_nettype none

// Request and read-data port between the bus controller and one RAM
interface mem_port_if #(
	parameter int AW = node_pkg::RAM_AW  // Word address width of the attached RAM
);
	import node_pkg::*;

	logic              en;     // One-clock pulse per access
	logic              we;     // High for a write, low for a read
	logic [STRB_W-1:0] be;     // Byte lanes to write
	logic [AW-1:0]     addr;   // Word address inside the RAM
	logic [DATA_W-1:0] wdata;  // Write data, all lanes
	logic [DATA_W-1:0] rdata;  // Valid MEM_LATENCY clocks after a read enable

	// Controller side issues requests and takes read data back
	modport ctrl (
		output en, we, be, addr, wdata,
		input  rdata
	);

	// Memory side
	modport mem (
		input  en, we, be, addr, wdata,
		output rdata
	);

endinterface

`default_nettype wire

// File: source/node_bus_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module node_bus_ctrl (
	input  logic                          clk,
	input  logic                          arst_n_i,
	input  logic                          psel_i,
	input  logic                          penable_i,
	input  logic                          pwrite_i,
	input  logic [node_pkg::ADDR_W-1:0]   paddr_i,
	input  logic [node_pkg::DATA_W-1:0]   pwdata_i,
	input  logic [node_pkg::STRB_W-1:0]   pstrb_i,
	output logic [node_pkg::DATA_W-1:0]   prdata_o,
	output logic                          pready_o,
	output logic                          pslverr_o,
	mem_port_if.ctrl                      ram_port,
	mem_port_if.ctrl                      spad_port,
	output logic [node_pkg::IRQ_W-1:0]    cause_idx_o,
	input  logic [node_pkg::DATA_W-1:0]   cause_data_i
);
	import node_pkg::*;

	typedef enum logic [1:0] {IDLE, WAIT, DONE} state_t;

	state_t               state_q;
	region_t              region_q;      // Region of the transfer in flight
	region_t              setup_region;  // Decode of the address in the setup cycle
	logic                 we_q;          // Transfer in flight is a write
	logic                 en_q;          // Single enable pulse for the selected RAM
	logic [LAT_CNT_W-1:0] cnt_q;         // Wait states left before pready
	logic [RAM_AW-1:0]    waddr_q;       // Word address, sized for the deepest region
	logic [DATA_W-1:0]    wdata_q;
	logic [STRB_W-1:0]    be_q;
	logic                 setup;
	logic                 bad_access;

	// ==================================================
	// Address decode
	// ==================================================
	// Subtracting the base wraps addresses below it to large offsets, so one
	// unsigned compare checks both ends of a region
	function automatic region_t decode(input logic [ADDR_W-1:0] addr);
		logic [ADDR_W-1:0] ram_off;
		logic [ADDR_W-1:0] spad_off;
		logic [ADDR_W-1:0] cause_off;
		ram_off   = (addr - RAM_BASE) >> 2;
		spad_off  = (addr - SPAD_BASE) >> 2;
		cause_off = (addr - CAUSE_BASE) >> 2;
		if (ram_off < ADDR_W'(RAM_WORDS))
			decode = REG_RAM;
		else if (spad_off < ADDR_W'(SPAD_WORDS))
			decode = REG_SPAD;
		else if (cause_off < ADDR_W'(IRQ_LEVELS))
			decode = REG_CAUSE;
		else
			decode = REG_NONE;  // Past a region's depth or simply unmapped
	endfunction

	assign setup        = psel_i && !penable_i;  // APB setup phase
	assign setup_region = decode(paddr_i);
	// The cause table is read only, so a write there is refused like a hole
	assign bad_access   = (setup_region == REG_NONE) ||
	                      (setup_region == REG_CAUSE && pwrite_i);

	// ==================================================
	// Transfer state machine
	// ==================================================
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q   <= IDLE;
			region_q  <= REG_NONE;
			we_q      <= 1'b0;
			en_q      <= 1'b0;
			cnt_q     <= '0;
			pready_o  <= 1'b0;
			pslverr_o <= 1'b0;
		end else begin
			en_q      <= 1'b0;  // Enable never lasts more than one clock
			pready_o  <= 1'b0;
			pslverr_o <= 1'b0;
			case (state_q)
				IDLE: begin
					if (setup) begin  // Bus is only looked at while idle
						region_q <= setup_region;
						we_q     <= pwrite_i;
						if (bad_access) begin
							// Refused in the first access cycle, nothing is written
							pready_o  <= 1'b1;
							pslverr_o <= 1'b1;
							state_q   <= DONE;
						end else if (setup_region == REG_CAUSE) begin
							pready_o <= 1'b1;  // Cause table answers without wait states
							state_q  <= DONE;
						end else begin
							// RAM sees en in the first access cycle
							en_q    <= 1'b1;
							cnt_q   <= LAT_CNT_W'(MEM_LATENCY - 1);
							state_q <= WAIT;
						end
					end
				end
				WAIT: begin
					if (cnt_q == '0) begin
						pready_o <= 1'b1;  // Read data is out of the RAM pipe by now
						state_q  <= DONE;
					end else begin
						cnt_q <= cnt_q - 1'b1;
					end
				end
				DONE: state_q <= IDLE;  // pready cycle, next setup may follow right away
				default: state_q <= IDLE;
			endcase
		end
	end

	// Address, data and strobes are held for the whole transfer
	always_ff @(posedge clk) begin
		if (state_q == IDLE && setup) begin
			waddr_q <= paddr_i[RAM_AW+1:2];
			wdata_q <= pwdata_i;
			be_q    <= pstrb_i;
		end
	end

	// ==================================================
	// Memory ports
	// ==================================================
	assign ram_port.en    = en_q && (region_q == REG_RAM);
	assign ram_port.we    = we_q;
	assign ram_port.be    = be_q;
	assign ram_port.addr  = waddr_q;
	assign ram_port.wdata = wdata_q;

	assign spad_port.en    = en_q && (region_q == REG_SPAD);
	assign spad_port.we    = we_q;
	assign spad_port.be    = be_q;
	assign spad_port.addr  = waddr_q[SPAD_AW-1:0];
	assign spad_port.wdata = wdata_q;

	assign cause_idx_o = waddr_q[IRQ_W-1:0];  // Level number is the word offset

	// Read data only counts in the pready cycle of a good read
	always_comb begin
		prdata_o = '0;
		if (pready_o && !pslverr_o && !we_q) begin
			case (region_q)
				REG_RAM:   prdata_o = ram_port.rdata;
				REG_SPAD:  prdata_o = spad_port.rdata;
				REG_CAUSE: prdata_o = cause_data_i;
				default:   prdata_o = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/node_ram.sv
`timescale 1ns/1ns
`default_nettype none

// Single port RAM with byte enables and a registered two-stage read
module node_ram #(
	parameter int WORDS = node_pkg::RAM_WORDS  // Depth in words, a power of two
) (
	input logic     clk,
	mem_port_if.mem port
);
	import node_pkg::*;

	logic [DATA_W-1:0] words_q [WORDS];  // Storage array
	logic [DATA_W-1:0] rd_stage_q;       // Address-phase data register
	logic [DATA_W-1:0] rd_out_q;         // Output register

	// ==================================================
	// Write path
	// ==================================================
	// Only the strobed byte lanes of the word change
	always_ff @(posedge clk) begin
		if (port.en && port.we) begin
			for (int i = 0; i < STRB_W; i++) begin
				if (port.be[i])
					words_q[port.addr][i*BYTE_W +: BYTE_W] <= port.wdata[i*BYTE_W +: BYTE_W];
			end
		end
	end

	// ==================================================
	// Read path
	// ==================================================
	// First stage loads only on a read, so a write leaves the output alone
	always_ff @(posedge clk) begin
		if (port.en && !port.we)
			rd_stage_q <= words_q[port.addr];
		rd_out_q <= rd_stage_q;  // Second stage gives the MEM_LATENCY of two
	end

	// Data stays put until the next read works its way through
	assign port.rdata = rd_out_q;

endmodule

`default_nettype wire

// File: source/irq_cause_table.sv
`timescale 1ns/1ns
`default_nettype none

module irq_cause_table (
	input  logic                         clk,
	input  logic                         arst_n_i,
	input  logic [node_pkg::IRQ_W-1:0]   irq_i,      // Requesting level, zero when quiet
	input  logic [node_pkg::CAUSE_W-1:0] cause_i,    // Cause code of the request
	input  logic [node_pkg::IRQ_W-1:0]   rd_idx_i,   // Level being read by the bus
	output logic [node_pkg::DATA_W-1:0]  rd_data_o
);
	import node_pkg::*;

	logic [CAUSE_W-1:0] cause_q [IRQ_LEVELS];  // One cause per priority level

	// Last cause per level wins. Level 0 is never written and stays zero
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < IRQ_LEVELS; i++)
				cause_q[i] <= '0;
		end else if (irq_i != '0) begin
			cause_q[irq_i] <= cause_i;
		end
	end

	// Combinational read, so a bus read right after the write sees the new code
	assign rd_data_o = DATA_W'(cause_q[rd_idx_i]);  // Zero extended to a bus word

endmodule

`default_nettype wire

// File: source/node_mem.sv
`timescale 1ns/1ns
`default_nettype none

// Local memory block of one node behind a single APB slave port
module node_mem (
	input  logic                         clk,
	input  logic                         arst_n_i,
	// APB slave
	input  logic                         psel_i,
	input  logic                         penable_i,
	input  logic                         pwrite_i,
	input  logic [node_pkg::ADDR_W-1:0]  paddr_i,
	input  logic [node_pkg::DATA_W-1:0]  pwdata_i,
	input  logic [node_pkg::STRB_W-1:0]  pstrb_i,
	output logic [node_pkg::DATA_W-1:0]  prdata_o,
	output logic                         pready_o,
	output logic                         pslverr_o,
	// Interrupt requests
	input  logic [node_pkg::IRQ_W-1:0]   irq_i,
	input  logic [node_pkg::CAUSE_W-1:0] cause_i
);
	import node_pkg::*;

	logic [IRQ_W-1:0]  cause_idx;   // Level selected by the controller
	logic [DATA_W-1:0] cause_data;  // Zero-extended cause back to the controller

	// One port per memory, each sized to its own depth
	mem_port_if #(.AW(RAM_AW))  ram_port ();
	mem_port_if #(.AW(SPAD_AW)) spad_port ();

	// ==================================================
	// Bus controller
	// ==================================================
	node_bus_ctrl u_ctrl (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.psel_i       (psel_i),
		.penable_i    (penable_i),
		.pwrite_i     (pwrite_i),
		.paddr_i      (paddr_i),
		.pwdata_i     (pwdata_i),
		.pstrb_i      (pstrb_i),
		.prdata_o     (prdata_o),
		.pready_o     (pready_o),
		.pslverr_o    (pslverr_o),
		.ram_port     (ram_port.ctrl),
		.spad_port    (spad_port.ctrl),
		.cause_idx_o  (cause_idx),
		.cause_data_i (cause_data)
	);

	// ==================================================
	// Datapath
	// ==================================================
	node_ram #(.WORDS(RAM_WORDS)) u_ram (
		.clk  (clk),
		.port (ram_port.mem)
	);

	node_ram #(.WORDS(SPAD_WORDS)) u_spad (
		.clk  (clk),
		.port (spad_port.mem)
	);

	irq_cause_table u_cause (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.irq_i     (irq_i),
		.cause_i   (cause_i),
		.rd_idx_i  (cause_idx),
		.rd_data_o (cause_data)
	);

endmodule

`default_nettype wire

// File: tb/node_mem_assertions.sv
`timescale 1ns/1ns
`default_nettype none

// Protocol checks on the APB side and the two RAM enables of the bus controller
module node_mem_assertions (
	input logic clk,
	input logic arst_n_i,
	input logic psel_i,
	input logic penable_i,
	input logic pready_i,
	input logic pslverr_i,
	input logic ram_en_i,
	input logic spad_en_i
);

	int fail_cnt;  // Number of failed assertions so far

	// pready belongs to an access cycle and never to setup or idle
	pready_in_access: assert property (@(posedge clk) disable iff (!arst_n_i)
		pready_i |-> (psel_i && penable_i))
		else begin
			fail_cnt++;
			$error("pready high outside an APB access cycle");
		end

	pslverr_with_pready: assert property (@(posedge clk) disable iff (!arst_n_i)
		pslverr_i |-> pready_i)
		else begin
			fail_cnt++;
			$error("pslverr high without pready");
		end

	// One enable pulse per RAM access
	ram_en_single: assert property (@(posedge clk) disable iff (!arst_n_i)
		ram_en_i |=> !ram_en_i)
		else begin
			fail_cnt++;
			$error("Main RAM enable held for more than one clock");
		end

	spad_en_single: assert property (@(posedge clk) disable iff (!arst_n_i)
		spad_en_i |=> !spad_en_i)
		else begin
			fail_cnt++;
			$error("Scratchpad enable held for more than one clock");
		end

	// Only one transfer is ever in flight
	ports_exclusive: assert property (@(posedge clk) disable iff (!arst_n_i)
		!(ram_en_i && spad_en_i))
		else begin
			fail_cnt++;
			$error("Both RAM ports enabled in the same clock");
		end

endmodule

`default_nettype wire

// File: tb/node_mem_tb.sv
`timescale 1ns/1ns
`default_nettype none

module node_mem_tb;
	import node_pkg::*;

	localparam int PERIOD     = 40;
	localparam int RST_CYCLES = 4;
	localparam int MAX_ACCESS = 8;               // Longest wait for pready before giving up
	localparam int RAND_WORDS = 8;
	localparam int RAND_OPS   = 4 * RAND_WORDS;  // Written and read back in both RAMs
	localparam int RAND_OFF   = 64;              // Word offset of the random block in each RAM

	logic               clk;
	logic               arst_n_i;
	logic               psel_i;
	logic               penable_i;
	logic               pwrite_i;
	logic [ADDR_W-1:0]  paddr_i;
	logic [DATA_W-1:0]  pwdata_i;
	logic [STRB_W-1:0]  pstrb_i;
	logic [DATA_W-1:0]  prdata_o;
	logic               pready_o;
	logic               pslverr_o;
	logic [IRQ_W-1:0]   irq_i;
	logic [CAUSE_W-1:0] cause_i;

	// One entry per case line
	byte               op_q[$];
	logic [ADDR_W-1:0] addr_q[$];  // Bus address or the level of an I line
	logic [DATA_W-1:0] data_q[$];  // Write data or the cause of an I line
	logic [STRB_W-1:0] strb_q[$];
	logic [DATA_W-1:0] exp_q[$];
	logic              err_q[$];

	int seed;
	int checks;
	int value_errs;
	int other_errs;
	int assert_errs;
	bit loaded;  // Case file has been read, watchdog may start

	node_mem DUT (.*);

	bind node_bus_ctrl node_mem_assertions u_assertions (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pready_i  (pready_o),
		.pslverr_i (pslverr_o),
		.ram_en_i  (ram_port.en),
		.spad_en_i (spad_port.en)
	);

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	// ==================================================
	// Case file and expected timing
	// ==================================================
	task automatic load_cases();
		int          fd;
		int          n;
		string       line;
		byte         op;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] e;
		logic [3:0]  s;
		logic        x;
		fd = $fopen("tb/node_mem_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the case file tb/node_mem_cases.txt");
			other_errs++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 0 && line[0] != "#") begin  // Lines with # are column notes
				n = $sscanf(line, "%c %h %h %h %h %h", op, a, d, s, e, x);
				if (n == 6) begin
					op_q.push_back(op);
					addr_q.push_back(a);
					data_q.push_back(d);
					strb_q.push_back(s);
					exp_q.push_back(e);
					err_q.push_back(x);
				end
			end
		end
		$fclose(fd);
	endtask

	// Cause table and refused transfers answer at once, RAMs after the read latency
	function automatic int expected_cycles(input logic [ADDR_W-1:0] addr, input logic err);
		if (err || (addr >= CAUSE_BASE && addr < CAUSE_BASE + 4 * IRQ_LEVELS))
			return 1;
		return MEM_LATENCY + 1;
	endfunction

	task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, got);
			value_errs++;
		end
	endtask

	// Collects the protocol assertion failures and prints all counts
	task automatic report_counts();
		assert_errs = DUT.u_ctrl.u_assertions.fail_cnt;
		$display("Checks: %0d, value errors: %0d, other errors: %0d, assertion failures: %0d",
		         checks, value_errs, other_errs, assert_errs);
	endtask

	// ==================================================
	// Bus and interrupt drivers
	// ==================================================
	task automatic apb_transfer(
		input  logic              write,
		input  logic [ADDR_W-1:0] addr,
		input  logic [DATA_W-1:0] wdata,
		input  logic [STRB_W-1:0] strb,
		output logic [DATA_W-1:0] rdata,
		output logic              err,
		output int                cycles
	);
		bit done;
		rdata  = '0;
		err    = 1'b0;
		cycles = 0;
		done   = 1'b0;
		@(posedge clk);
		#2;
		psel_i    = 1'b1;  // Setup cycle
		penable_i = 1'b0;
		pwrite_i  = write;
		paddr_i   = addr;
		pwdata_i  = wdata;
		pstrb_i   = strb;
		@(posedge clk);
		#2;
		penable_i = 1'b1;
		while (!done && cycles < MAX_ACCESS) begin
			@(negedge clk);  // Outputs have settled by the middle of an access cycle
			cycles++;
			if (pready_o) begin
				done  = 1'b1;
				rdata = prdata_o;
				err   = pslverr_o;
			end
		end
		if (!done) begin
			$display("No pready from the DUT after %0d access cycles at address %h",
			         MAX_ACCESS, addr);
			other_errs++;
		end
		@(posedge clk);
		#2;
		psel_i    = 1'b0;
		penable_i = 1'b0;
	endtask

	task automatic pulse_irq(input logic [IRQ_W-1:0] level, input logic [CAUSE_W-1:0] code);
		@(posedge clk);
		#2;
		irq_i   = level;
		cause_i = code;
		@(posedge clk);  // Table takes the code at this edge
		#2;
		irq_i   = '0;
		cause_i = '0;
	endtask

	task automatic run_case(input int i);
		logic [DATA_W-1:0] rd;
		logic              er;
		int                cyc;
		if (op_q[i] == "I") begin
			pulse_irq(addr_q[i][IRQ_W-1:0], data_q[i][CAUSE_W-1:0]);
		end else if (op_q[i] == "W" || op_q[i] == "R") begin
			apb_transfer(op_q[i] == "W", addr_q[i], data_q[i], strb_q[i], rd, er, cyc);
			compare_word("pslverr_o", 32'(err_q[i]), 32'(er));
			compare_word("pready_o access cycle",
			             32'(expected_cycles(addr_q[i], err_q[i])), 32'(cyc));
			if (op_q[i] == "R")
				compare_word("prdata_o", exp_q[i], rd);
		end else begin
			$display("Case %0d has an unknown operation letter %c", i, op_q[i]);
			other_errs++;
		end
	endtask

	// Same word offsets in both RAMs with different random data
	task automatic random_block();
		logic [DATA_W-1:0] ram_words [RAND_WORDS];
		logic [DATA_W-1:0] spad_words [RAND_WORDS];
		logic [DATA_W-1:0] rd;
		logic              er;
		int                cyc;
		for (int i = 0; i < RAND_WORDS; i++) begin
			ram_words[i]  = $random(seed);
			spad_words[i] = $random(seed);
			apb_transfer(1'b1, RAM_BASE + 4 * (RAND_OFF + i), ram_words[i], 4'hf, rd, er, cyc);
			apb_transfer(1'b1, SPAD_BASE + 4 * (RAND_OFF + i), spad_words[i], 4'hf, rd, er, cyc);
		end
		for (int i = 0; i < RAND_WORDS; i++) begin
			apb_transfer(1'b0, RAM_BASE + 4 * (RAND_OFF + i), '0, '0, rd, er, cyc);
			compare_word("prdata_o", ram_words[i], rd);
			apb_transfer(1'b0, SPAD_BASE + 4 * (RAND_OFF + i), '0, '0, rd, er, cyc);
			compare_word("prdata_o", spad_words[i], rd);
		end
	endtask

	// ==================================================
	// Main sequence and watchdog
	// ==================================================
	initial begin
		seed        = 32'h6dcbeeaa;
		checks      = 0;
		value_errs  = 0;
		other_errs  = 0;
		assert_errs = 0;
		arst_n_i    = 1'b0;
		psel_i      = 1'b0;
		penable_i   = 1'b0;
		pwrite_i    = 1'b0;
		paddr_i     = '0;
		pwdata_i    = '0;
		pstrb_i     = '0;
		irq_i       = '0;
		cause_i     = '0;
		load_cases();
		loaded = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		#2;
		arst_n_i = 1'b1;
		@(negedge clk);
		compare_word("pready_o", 32'h0, 32'(pready_o));  // Quiet bus straight after reset
		compare_word("pslverr_o", 32'h0, 32'(pslverr_o));
		compare_word("prdata_o", 32'h0, prdata_o);
		for (int i = 0; i < op_q.size(); i++)
			run_case(i);
		random_block();
		report_counts();
		if (value_errs == 0 && other_errs == 0 && assert_errs == 0 && op_q.size() > 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// Six clocks per operation is well above the longest transfer
	initial begin
		wait (loaded);
		#((op_q.size() + RAND_OPS) * 6 * PERIOD + RST_CYCLES * PERIOD);
		$display("The run timed out before all cases were done");
		report_counts();
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/node_mem_cases.txt
# op addr_or_level data_or_cause strobe expected_rdata expected_err (hex)
# op is W write, R read, I interrupt; unused fields hold 0
R 00050000 00000000 0 00000000 0
R 00050004 00000000 0 00000000 0
R 00050008 00000000 0 00000000 0
R 0005000c 00000000 0 00000000 0
R 00050010 00000000 0 00000000 0
R 00050014 00000000 0 00000000 0
R 00050018 00000000 0 00000000 0
R 0005001c 00000000 0 00000000 0
W 00000000 11223344 f 00000000 0
R 00000000 00000000 0 11223344 0
W 00000000 ddccbbaa 5 00000000 0
R 00000000 00000000 0 11cc33aa 0
W 00040010 cafef00d f 00000000 0
W 00040010 12345678 8 00000000 0
R 00040010 00000000 0 12fef00d 0
W 00000010 0badbeef f 00000000 0
R 00000010 00000000 0 0badbeef 0
R 00040010 00000000 0 12fef00d 0
W 00040000 600dd00d f 00000000 0
I 00000003 0000005a 0 00000000 0
I 00000007 000000c3 0 00000000 0
I 00000003 00000081 0 00000000 0
I 00000001 0000000f 0 00000000 0
R 0005000c 00000000 0 00000081 0
R 0005001c 00000000 0 000000c3 0
R 00050004 00000000 0 0000000f 0
R 00050000 00000000 0 00000000 0
W 00080000 ffffffff f 00000000 1
W 00001000 ffffffff f 00000000 1
W 00040400 ffffffff f 00000000 1
W 00050008 ffffffff f 00000000 1
R 00050020 00000000 0 00000000 1
R 00080000 00000000 0 00000000 1
R 00000000 00000000 0 11cc33aa 0
R 00040000 00000000 0 600dd00d 0
R 00050008 00000000 0 00000000 0

// File: node_mem.f
source/node_pkg.sv
source/mem_port_if.sv
source/node_bus_ctrl.sv
source/node_ram.sv
source/irq_cause_table.sv
source/node_mem.sv
tb/node_mem_assertions.sv
tb/node_mem_tb.sv

// File: run.sh
#!/bin/sh
# Builds the node_mem testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f node_mem.f --top-module node_mem_tb -o node_mem_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/node_mem_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1
